// File: src/npu_macros.svh
`ifndef NPU_MACROS_SVH
`define NPU_MACROS_SVH

// ------------------------------
// datapath widths
// ------------------------------
// stream beat and sram word
`define NPU_DATA_W 64
// int8 lanes packed into one word
`define NPU_LANES 8
`define NPU_LANE_W 8

// ------------------------------
// bank geometry
// ------------------------------
// 64 words per bank
`define NPU_ADDR_W 6
`define NPU_DEPTH 64
// one bit wider than the address so a full bank (64) fits
`define NPU_CNT_W 7

`endif

// File: src/npu_pkg.sv
`default_nettype none
`include "npu_macros.svh"

package npu_pkg;

    // elementwise operation selected per layer
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_e;

    // operand bank carried on the input stream's tuser bit
    typedef enum logic {
        BANK_A = 1'b0,
        BANK_B = 1'b1
    } bank_e;

    typedef logic signed [`NPU_LANE_W-1:0] int8_t;

    // one sram word, raw stream bits or eight int8 lanes
    // lane 0 sits in the lowest byte
    typedef union packed {
        logic [`NPU_DATA_W-1:0]  raw;
        int8_t [`NPU_LANES-1:0]  lanes;
    } lane_word_u;

endpackage

`default_nettype wire

// File: src/sram_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

// single-port sram access, read data one cycle after en with we low
interface sram_if #(
    parameter int RDATA_W = `NPU_DATA_W
) ();

    logic                   en;
    logic                   we;
    logic [`NPU_ADDR_W-1:0] addr;
    logic [`NPU_DATA_W-1:0] wdata;
    logic [RDATA_W-1:0]     rdata;

    modport master (
        output en, we, addr, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: src/stream_loader.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module stream_loader (
    input  logic                   s00_axis_aclk,
    input  logic                   rst_n_i,
    input  logic                   load_en_i,
    input  logic [`NPU_DATA_W-1:0] tdata_i,
    input  npu_pkg::bank_e         tuser_i,
    input  logic                   tvalid_i,
    input  logic                   tlast_i,
    output logic                   tready_o,
    sram_if.master                 bank_a_wr,
    sram_if.master                 bank_b_wr,
    output logic                   load_done_o
);
    import npu_pkg::*;

    logic [`NPU_ADDR_W-1:0] addr_a_q;
    logic [`NPU_ADDR_W-1:0] addr_b_q;
    logic                   last_a_q;
    logic                   last_b_q;
    logic                   wr_a;
    logic                   wr_b;

    // accept for the whole load phase
    assign tready_o = load_en_i;

    assign wr_a = load_en_i && tvalid_i && (tuser_i == BANK_A);
    assign wr_b = load_en_i && tvalid_i && (tuser_i == BANK_B);

    assign bank_a_wr.en    = wr_a;
    assign bank_a_wr.we    = wr_a;
    assign bank_a_wr.addr  = addr_a_q;
    assign bank_a_wr.wdata = tdata_i;

    assign bank_b_wr.en    = wr_b;
    assign bank_b_wr.we    = wr_b;
    assign bank_b_wr.addr  = addr_b_q;
    assign bank_b_wr.wdata = tdata_i;

    assign load_done_o = last_a_q && last_b_q;

    always_ff @(posedge s00_axis_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_a_q <= '0;
            addr_b_q <= '0;
            last_a_q <= 1'b0;
            last_b_q <= 1'b0;
        end else begin
            // address restarts at each packet end
            if (wr_a) begin
                addr_a_q <= tlast_i ? '0 : addr_a_q + 1'b1;
            end
            if (wr_b) begin
                addr_b_q <= tlast_i ? '0 : addr_b_q + 1'b1;
            end
            if (!load_en_i) begin
                last_a_q <= 1'b0;
                last_b_q <= 1'b0;
            end else begin
                last_a_q <= last_a_q || (wr_a && tlast_i);
                last_b_q <= last_b_q || (wr_b && tlast_i);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/sram_banks.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module sram_banks (
    input  logic   s00_axis_aclk,
    sram_if.slave  bank_a_wr,
    sram_if.slave  bank_b_wr,
    sram_if.slave  operand_rd,
    sram_if.slave  result_wr,
    sram_if.slave  result_rd
);

    localparam int IDX_A   = 0;
    localparam int IDX_B   = 1;
    localparam int IDX_RES = 2;
    localparam int NBANKS  = 3;

    // one physical port per bank after steering
    logic                   p_en    [NBANKS];
    logic                   p_we    [NBANKS];
    logic [`NPU_ADDR_W-1:0] p_addr  [NBANKS];
    logic [`NPU_DATA_W-1:0] p_wdata [NBANKS];

    logic [`NPU_DATA_W-1:0] mem_q   [NBANKS][`NPU_DEPTH];
    logic [`NPU_DATA_W-1:0] rdata_q [NBANKS];

    // ------------------------------
    // port steering
    // ------------------------------
    always_comb begin
        // loader wins on operand banks
        p_en[IDX_A]    = bank_a_wr.en || operand_rd.en;
        p_we[IDX_A]    = bank_a_wr.en ? bank_a_wr.we : operand_rd.we;
        p_addr[IDX_A]  = bank_a_wr.en ? bank_a_wr.addr : operand_rd.addr;
        p_wdata[IDX_A] = bank_a_wr.en ? bank_a_wr.wdata : operand_rd.wdata;

        p_en[IDX_B]    = bank_b_wr.en || operand_rd.en;
        p_we[IDX_B]    = bank_b_wr.en ? bank_b_wr.we : operand_rd.we;
        p_addr[IDX_B]  = bank_b_wr.en ? bank_b_wr.addr : operand_rd.addr;
        p_wdata[IDX_B] = bank_b_wr.en ? bank_b_wr.wdata : operand_rd.wdata;

        // compute writes and output reads never overlap
        p_en[IDX_RES]    = result_wr.en || result_rd.en;
        p_we[IDX_RES]    = result_wr.en ? result_wr.we : result_rd.we;
        p_addr[IDX_RES]  = result_wr.en ? result_wr.addr : result_rd.addr;
        p_wdata[IDX_RES] = result_wr.en ? result_wr.wdata : result_rd.wdata;
    end

    // ------------------------------
    // arrays, registered read
    // ------------------------------
    always_ff @(posedge s00_axis_aclk) begin
        for (int b = 0; b < NBANKS; b++) begin
            if (p_en[b]) begin
                if (p_we[b]) begin
                    mem_q[b][p_addr[b]] <= p_wdata[b];
                end else begin
                    rdata_q[b] <= mem_q[b][p_addr[b]];
                end
            end
        end
    end

    // operand a low half, operand b high half
    assign operand_rd.rdata = {rdata_q[IDX_B], rdata_q[IDX_A]};
    assign bank_a_wr.rdata  = rdata_q[IDX_A];
    assign bank_b_wr.rdata  = rdata_q[IDX_B];
    assign result_wr.rdata  = rdata_q[IDX_RES];
    assign result_rd.rdata  = rdata_q[IDX_RES];

endmodule

`default_nettype wire

// File: src/elementwise_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module elementwise_unit (
    input  logic                  s00_axis_aclk,
    input  logic                  rst_n_i,
    input  logic                  compute_en_i,
    input  npu_pkg::op_e          op_i,
    input  logic [`NPU_CNT_W-1:0] count_i,
    sram_if.master                operand_rd,
    sram_if.master                result_wr,
    output logic                  compute_done_o
);
    import npu_pkg::*;

    logic [`NPU_CNT_W-1:0]  rd_cnt_q;
    logic [`NPU_CNT_W-1:0]  wr_cnt_q;
    logic                   rd_issue;
    logic                   s1_v_q;
    logic [`NPU_ADDR_W-1:0] s1_addr_q;
    logic                   s2_v_q;
    logic [`NPU_ADDR_W-1:0] s2_addr_q;
    lane_word_u             a_w;
    lane_word_u             b_w;
    lane_word_u             res_w;
    lane_word_u             s2_word_q;

    // one lane widened to 16 bits then clamped to int8
    function automatic int8_t lane_calc(input op_e op, input int8_t a, input int8_t b);
        logic signed [15:0] wide;
        case (op)
            OP_ADD:  wide = 16'(a) + 16'(b);
            OP_SUB:  wide = 16'(a) - 16'(b);
            OP_MUL:  wide = 16'(a) * 16'(b);
            default: wide = '0;
        endcase
        if (wide > 16'sd127) begin
            return 8'sh7f;
        end
        if (wide < -16'sd128) begin
            return 8'sh80;
        end
        return wide[7:0];
    endfunction

    // ------------------------------
    // stage 0 issues the reads
    // ------------------------------
    assign rd_issue = compute_en_i && (rd_cnt_q != count_i);

    assign operand_rd.en    = rd_issue;
    assign operand_rd.we    = 1'b0;
    assign operand_rd.addr  = rd_cnt_q[`NPU_ADDR_W-1:0];
    assign operand_rd.wdata = '0;

    // stage 1 sees both operands back from the banks
    always_comb begin
        a_w.raw = operand_rd.rdata[`NPU_DATA_W-1:0];
        b_w.raw = operand_rd.rdata[2*`NPU_DATA_W-1:`NPU_DATA_W];
        for (int i = 0; i < `NPU_LANES; i++) begin
            res_w.lanes[i] = lane_calc(op_i, a_w.lanes[i], b_w.lanes[i]);
        end
    end

    // stage 2 writes the registered result to the result bank
    assign result_wr.en    = s2_v_q;
    assign result_wr.we    = s2_v_q;
    assign result_wr.addr  = s2_addr_q;
    assign result_wr.wdata = s2_word_q.raw;

    // high during the final write
    assign compute_done_o = s2_v_q && (wr_cnt_q + 1'b1 == count_i);

    always_ff @(posedge s00_axis_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
            s1_v_q   <= 1'b0;
            s2_v_q   <= 1'b0;
        end else if (!compute_en_i) begin
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
            s1_v_q   <= 1'b0;
            s2_v_q   <= 1'b0;
        end else begin
            if (rd_issue) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            s1_v_q <= rd_issue;
            s2_v_q <= s1_v_q;
            if (s2_v_q) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end
        end
    end

    // address and data ride alongside the valid bits
    always_ff @(posedge s00_axis_aclk) begin
        s1_addr_q <= operand_rd.addr;
        s2_addr_q <= s1_addr_q;
        s2_word_q <= res_w;
    end

endmodule

`default_nettype wire

// File: src/layer_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module layer_controller (
    input  logic                  s00_axis_aclk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  npu_pkg::op_e          op_i,
    input  logic [`NPU_CNT_W-1:0] count_i,
    input  logic                  load_done_i,
    input  logic                  compute_done_i,
    input  logic                  write_done_i,
    output logic                  load_en_o,
    output logic                  compute_en_o,
    output logic                  write_en_o,
    output npu_pkg::op_e          op_o,
    output logic [`NPU_CNT_W-1:0] count_o,
    output logic                  done_o
);
    import npu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_COMPUTE,
        S_DONE,
        S_WRITE
    } state_e;

    state_e                state_q;
    state_e                state_d;
    op_e                   op_q;
    logic [`NPU_CNT_W-1:0] count_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:    if (start_i) state_d = S_LOAD;
            S_LOAD:    if (load_done_i) state_d = S_COMPUTE;
            S_COMPUTE: if (compute_done_i) state_d = S_DONE;
            // single cycle, gives the done pulse
            S_DONE:    state_d = S_WRITE;
            S_WRITE:   if (write_done_i) state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge s00_axis_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            op_q    <= OP_ADD;
            count_q <= '0;
        end else begin
            state_q <= state_d;
            // layer config held for the whole layer
            if (state_q == S_IDLE && start_i) begin
                op_q    <= op_i;
                count_q <= count_i;
            end
        end
    end

    assign load_en_o    = (state_q == S_LOAD);
    assign compute_en_o = (state_q == S_COMPUTE);
    assign write_en_o   = (state_q == S_WRITE);
    assign done_o       = (state_q == S_DONE);
    assign op_o         = op_q;
    assign count_o      = count_q;

endmodule

`default_nettype wire

// File: src/stream_writer.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module stream_writer (
    input  logic                   s00_axis_aclk,
    input  logic                   rst_n_i,
    input  logic                   write_en_i,
    input  logic [`NPU_CNT_W-1:0]  count_i,
    sram_if.master                 result_rd,
    output logic [`NPU_DATA_W-1:0] tdata_o,
    output logic                   tvalid_o,
    output logic                   tlast_o,
    input  logic                   tready_i,
    output logic                   write_done_o
);

    logic [`NPU_CNT_W-1:0]  rd_cnt_q;
    logic                   pend_q;
    logic                   pend_last_q;
    logic                   hold_v_q;
    logic                   hold_last_q;
    logic [`NPU_DATA_W-1:0] hold_data_q;
    logic                   adv;
    logic                   rd_issue;

    // holding register empty or emptying this cycle
    assign adv      = !hold_v_q || tready_i;
    assign rd_issue = write_en_i && adv && (rd_cnt_q != count_i);

    assign result_rd.en    = rd_issue;
    assign result_rd.we    = 1'b0;
    assign result_rd.addr  = rd_cnt_q[`NPU_ADDR_W-1:0];
    assign result_rd.wdata = '0;

    assign tdata_o      = hold_data_q;
    assign tvalid_o     = hold_v_q;
    assign tlast_o      = hold_v_q && hold_last_q;
    assign write_done_o = hold_v_q && hold_last_q && tready_i;

    // ------------------------------
    // read in flight, then holding
    // ------------------------------
    always_ff @(posedge s00_axis_aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_cnt_q    <= '0;
            pend_q      <= 1'b0;
            pend_last_q <= 1'b0;
            hold_v_q    <= 1'b0;
            hold_last_q <= 1'b0;
        end else begin
            if (!write_en_i) begin
                rd_cnt_q <= '0;
            end else if (rd_issue) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            // bank rdata stays put while the pipe is stalled
            if (adv) begin
                pend_q      <= rd_issue;
                pend_last_q <= (rd_cnt_q == count_i - 1'b1);
                hold_v_q    <= pend_q;
                hold_last_q <= pend_last_q;
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (adv && pend_q) begin
            hold_data_q <= result_rd.rdata;
        end
    end

endmodule

`default_nettype wire

// File: src/npu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module npu_top (
    input  logic                   s00_axis_aclk,
    input  logic                   rst_n_i,
    input  logic [`NPU_DATA_W-1:0] s_axis_tdata_i,
    input  npu_pkg::bank_e         s_axis_tuser_i,
    input  logic                   s_axis_tvalid_i,
    input  logic                   s_axis_tlast_i,
    output logic                   s_axis_tready_o,
    output logic [`NPU_DATA_W-1:0] m_axis_tdata_o,
    output logic                   m_axis_tvalid_o,
    output logic                   m_axis_tlast_o,
    input  logic                   m_axis_tready_i,
    input  logic                   start_i,
    input  npu_pkg::op_e           op_i,
    input  logic [`NPU_CNT_W-1:0]  count_i,
    output logic                   done_o
);
    import npu_pkg::*;

    logic                  load_en;
    logic                  compute_en;
    logic                  write_en;
    logic                  load_done;
    logic                  compute_done;
    logic                  write_done;
    op_e                   layer_op;
    logic [`NPU_CNT_W-1:0] layer_count;

    sram_if                                 bank_a_if ();
    sram_if                                 bank_b_if ();
    sram_if #(.RDATA_W(2*`NPU_DATA_W))      operand_if ();
    sram_if                                 result_wr_if ();
    sram_if                                 result_rd_if ();

    layer_controller layer_controller_inst (
        .s00_axis_aclk  (s00_axis_aclk),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .op_i           (op_i),
        .count_i        (count_i),
        .load_done_i    (load_done),
        .compute_done_i (compute_done),
        .write_done_i   (write_done),
        .load_en_o      (load_en),
        .compute_en_o   (compute_en),
        .write_en_o     (write_en),
        .op_o           (layer_op),
        .count_o        (layer_count),
        .done_o         (done_o)
    );

    stream_loader stream_loader_inst (
        .s00_axis_aclk (s00_axis_aclk),
        .rst_n_i       (rst_n_i),
        .load_en_i     (load_en),
        .tdata_i       (s_axis_tdata_i),
        .tuser_i       (s_axis_tuser_i),
        .tvalid_i      (s_axis_tvalid_i),
        .tlast_i       (s_axis_tlast_i),
        .tready_o      (s_axis_tready_o),
        .bank_a_wr     (bank_a_if.master),
        .bank_b_wr     (bank_b_if.master),
        .load_done_o   (load_done)
    );

    sram_banks sram_banks_inst (
        .s00_axis_aclk (s00_axis_aclk),
        .bank_a_wr     (bank_a_if.slave),
        .bank_b_wr     (bank_b_if.slave),
        .operand_rd    (operand_if.slave),
        .result_wr     (result_wr_if.slave),
        .result_rd     (result_rd_if.slave)
    );

    elementwise_unit elementwise_unit_inst (
        .s00_axis_aclk  (s00_axis_aclk),
        .rst_n_i        (rst_n_i),
        .compute_en_i   (compute_en),
        .op_i           (layer_op),
        .count_i        (layer_count),
        .operand_rd     (operand_if.master),
        .result_wr      (result_wr_if.master),
        .compute_done_o (compute_done)
    );

    stream_writer stream_writer_inst (
        .s00_axis_aclk (s00_axis_aclk),
        .rst_n_i       (rst_n_i),
        .write_en_i    (write_en),
        .count_i       (layer_count),
        .result_rd     (result_rd_if.master),
        .tdata_o       (m_axis_tdata_o),
        .tvalid_o      (m_axis_tvalid_o),
        .tlast_o       (m_axis_tlast_o),
        .tready_i      (m_axis_tready_i),
        .write_done_o  (write_done)
    );

endmodule

`default_nettype wire

// File: testbench/npu_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module npu_checker (
    input  logic                   s00_axis_aclk,
    input  logic                   rst_n_i,
    input  logic [`NPU_DATA_W-1:0] s_tdata_i,
    input  npu_pkg::bank_e         s_tuser_i,
    input  logic                   s_tvalid_i,
    input  logic                   s_tlast_i,
    input  logic                   s_tready_i,
    input  logic [`NPU_DATA_W-1:0] m_tdata_i,
    input  logic                   m_tvalid_i,
    input  logic                   m_tlast_i,
    input  logic                   m_tready_i,
    input  logic                   start_i,
    input  npu_pkg::op_e           op_i,
    input  logic [`NPU_CNT_W-1:0]  count_i,
    input  logic                   done_i,
    output int                     value_errs_o,
    output int                     event_errs_o,
    output int                     layers_o
);
    import npu_pkg::*;

    logic [`NPU_DATA_W-1:0] bank_a_q [`NPU_DEPTH];
    logic [`NPU_DATA_W-1:0] bank_b_q [`NPU_DEPTH];
    int                     addr_a;
    int                     addr_b;
    logic                   busy;
    op_e                    layer_op;
    int                     layer_count;
    int                     beat;
    int                     done_seen;
    logic                   stall;
    logic [`NPU_DATA_W-1:0] prev_data;
    logic                   prev_last;

    // reference lanes: exact integer result, clamped to int8
    function automatic logic [`NPU_DATA_W-1:0] expected_word(input op_e op,
            input logic [`NPU_DATA_W-1:0] a, input logic [`NPU_DATA_W-1:0] b);
        logic [`NPU_DATA_W-1:0] w;
        int                     x;
        int                     y;
        int                     r;
        w = '0;
        for (int i = 0; i < `NPU_LANES; i++) begin
            x = int'($signed(a[i*`NPU_LANE_W +: `NPU_LANE_W]));
            y = int'($signed(b[i*`NPU_LANE_W +: `NPU_LANE_W]));
            case (op)
                OP_ADD:  r = x + y;
                OP_SUB:  r = x - y;
                OP_MUL:  r = x * y;
                default: r = 0;
            endcase
            if (r > 127) begin
                r = 127;
            end else if (r < -128) begin
                r = -128;
            end
            w[i*`NPU_LANE_W +: `NPU_LANE_W] = r[7:0];
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
            input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h (layer %0d, beat %0d)",
                     name, got, exp, layers_o, beat);
            value_errs_o++;
        end
    endtask

    task automatic report_event(input string msg);
        $display("%s (layer %0d)", msg, layers_o);
        event_errs_o++;
    endtask

    // ------------------------------
    // sampled on the falling edge
    // ------------------------------
    always @(negedge s00_axis_aclk) begin
        if (!rst_n_i) begin
            busy  = 1'b0;
            stall = 1'b0;
        end else if (!busy) begin
            // idle, every output quiet
            compare_value("s_axis_tready_o", 64'(s_tready_i), 64'd0);
            compare_value("m_axis_tvalid_o", 64'(m_tvalid_i), 64'd0);
            compare_value("m_axis_tlast_o", 64'(m_tlast_i), 64'd0);
            compare_value("done_o", 64'(done_i), 64'd0);
            if (start_i) begin
                busy        = 1'b1;
                layer_op    = op_i;
                layer_count = int'(count_i);
                beat        = 0;
                done_seen   = 0;
                addr_a      = 0;
                addr_b      = 0;
                stall       = 1'b0;
            end
        end else begin
            if (s_tvalid_i && s_tready_i) begin
                if (s_tuser_i == BANK_A) begin
                    bank_a_q[addr_a] = s_tdata_i;
                    addr_a = s_tlast_i ? 0 : addr_a + 1;
                end else begin
                    bank_b_q[addr_b] = s_tdata_i;
                    addr_b = s_tlast_i ? 0 : addr_b + 1;
                end
            end
            if (done_i) begin
                if (done_seen > 0) begin
                    report_event("done_o stayed high or pulsed a second time");
                end
                done_seen++;
            end
            // back-pressure must freeze the output beat
            if (stall) begin
                compare_value("m_axis_tvalid_o", 64'(m_tvalid_i), 64'd1);
                compare_value("m_axis_tdata_o", m_tdata_i, prev_data);
                compare_value("m_axis_tlast_o", 64'(m_tlast_i), 64'(prev_last));
            end
            if (m_tvalid_i && m_tready_i) begin
                if (done_seen == 0) begin
                    report_event("output beat arrived before the done_o pulse");
                end
                if (beat >= layer_count) begin
                    report_event("extra output beat after the layer count");
                end else begin
                    compare_value("m_axis_tdata_o", m_tdata_i,
                                  expected_word(layer_op, bank_a_q[beat], bank_b_q[beat]));
                    compare_value("m_axis_tlast_o", 64'(m_tlast_i),
                                  64'(beat == layer_count - 1));
                end
                beat++;
                if (m_tlast_i) begin
                    if (done_seen == 0) begin
                        report_event("layer ended without any done_o pulse");
                    end
                    busy = 1'b0;
                    layers_o++;
                end
            end
            stall     = m_tvalid_i && !m_tready_i;
            prev_data = m_tdata_i;
            prev_last = m_tlast_i;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_npu.sv
`timescale 1ns/1ns
`default_nettype none
`include "npu_macros.svh"

module tb_npu;
    import npu_pkg::*;

    localparam int          N_LAYERS    = 8;
    localparam int          CYCLE_LIMIT = N_LAYERS * (4 * `NPU_DEPTH + 50);
    localparam logic [31:0] SEED        = 32'hdbd9;

    logic                   s00_axis_aclk;
    logic                   rst_n_i;
    logic [`NPU_DATA_W-1:0] s_axis_tdata_i;
    bank_e                  s_axis_tuser_i;
    logic                   s_axis_tvalid_i;
    logic                   s_axis_tlast_i;
    logic                   s_axis_tready_o;
    logic [`NPU_DATA_W-1:0] m_axis_tdata_o;
    logic                   m_axis_tvalid_o;
    logic                   m_axis_tlast_o;
    logic                   m_axis_tready_i = 1'b0;
    logic                   start_i;
    op_e                    op_i;
    logic [`NPU_CNT_W-1:0]  count_i;
    logic                   done_o;

    logic [31:0] stim_state;
    logic [31:0] ready_state = SEED;
    int          cycles = 0;
    int          value_errs;
    int          event_errs;
    int          layers_seen;

    npu_top npu_top_inst (
        .s00_axis_aclk   (s00_axis_aclk),
        .rst_n_i         (rst_n_i),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tuser_i  (s_axis_tuser_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tready_o (s_axis_tready_o),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tready_i (m_axis_tready_i),
        .start_i         (start_i),
        .op_i            (op_i),
        .count_i         (count_i),
        .done_o          (done_o)
    );

    npu_checker npu_checker_inst (
        .s00_axis_aclk (s00_axis_aclk),
        .rst_n_i       (rst_n_i),
        .s_tdata_i     (s_axis_tdata_i),
        .s_tuser_i     (s_axis_tuser_i),
        .s_tvalid_i    (s_axis_tvalid_i),
        .s_tlast_i     (s_axis_tlast_i),
        .s_tready_i    (s_axis_tready_o),
        .m_tdata_i     (m_axis_tdata_o),
        .m_tvalid_i    (m_axis_tvalid_o),
        .m_tlast_i     (m_axis_tlast_o),
        .m_tready_i    (m_axis_tready_i),
        .start_i       (start_i),
        .op_i          (op_i),
        .count_i       (count_i),
        .done_i        (done_o),
        .value_errs_o  (value_errs),
        .event_errs_o  (event_errs),
        .layers_o      (layers_seen)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        s00_axis_aclk = 1'b0;
        forever #50 s00_axis_aclk = ~s00_axis_aclk;
    end

    // output back-pressure with ready about three cycles in four
    always @(posedge s00_axis_aclk) begin
        ready_state = xorshift32(ready_state);
        m_axis_tready_i <= (ready_state[1:0] != 2'b00);
    end

    always @(posedge s00_axis_aclk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d value, %0d event", value_errs, event_errs);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    // random word where extreme mode forces most lanes to 7f, 80 or 81
    task automatic gen_word(input logic extreme, output logic [`NPU_DATA_W-1:0] w);
        stim_state = xorshift32(stim_state);
        w[31:0] = stim_state;
        stim_state = xorshift32(stim_state);
        w[63:32] = stim_state;
        if (extreme) begin
            for (int i = 0; i < `NPU_LANES; i++) begin
                case (w[i*`NPU_LANE_W +: 2])
                    2'd0:    w[i*`NPU_LANE_W +: `NPU_LANE_W] = 8'h7f;
                    2'd1:    w[i*`NPU_LANE_W +: `NPU_LANE_W] = 8'h80;
                    2'd2:    w[i*`NPU_LANE_W +: `NPU_LANE_W] = 8'h81;
                    default: ;
                endcase
            end
        end
    endtask

    task automatic send_packet(input bank_e bank, input int n, input logic extreme);
        logic [`NPU_DATA_W-1:0] w;
        for (int i = 0; i < n; i++) begin
            gen_word(extreme, w);
            s_axis_tdata_i  <= w;
            s_axis_tuser_i  <= bank;
            s_axis_tvalid_i <= 1'b1;
            s_axis_tlast_i  <= (i == n - 1);
            @(negedge s00_axis_aclk);
            while (!s_axis_tready_o) begin
                @(negedge s00_axis_aclk);
            end
            @(posedge s00_axis_aclk);
        end
        s_axis_tvalid_i <= 1'b0;
        s_axis_tlast_i  <= 1'b0;
    endtask

    task automatic run_layer(input int idx);
        op_e                   op;
        logic [`NPU_CNT_W-1:0] cnt;
        logic                  extreme;
        logic                  b_first;
        stim_state = xorshift32(stim_state);
        // first six layers sweep add, sub, mul with plain then extreme data
        op      = (idx < 6) ? op_e'(2'(idx % 3)) : op_e'(2'(stim_state % 3));
        extreme = (idx >= 3 && idx < 6) || (idx >= 6 && stim_state[4]);
        b_first = stim_state[8];
        cnt     = `NPU_CNT_W'(stim_state[21:16] % 64) + 1'b1;
        if (idx == 0) begin
            cnt = `NPU_CNT_W'(`NPU_DEPTH);
        end else if (idx == 1) begin
            cnt = 1;
        end
        @(posedge s00_axis_aclk);
        start_i <= 1'b1;
        op_i    <= op;
        count_i <= cnt;
        @(posedge s00_axis_aclk);
        // the layer has to run on the config latched at start
        start_i <= 1'b0;
        op_i    <= op_e'(2'(stim_state[13:12] % 3));
        count_i <= ~cnt;
        send_packet(b_first ? BANK_B : BANK_A, int'(cnt), extreme);
        send_packet(b_first ? BANK_A : BANK_B, int'(cnt), extreme);
        @(negedge s00_axis_aclk);
        while (!(m_axis_tvalid_o && m_axis_tready_i && m_axis_tlast_o)) begin
            @(negedge s00_axis_aclk);
        end
        @(posedge s00_axis_aclk);
    endtask

    initial begin
        stim_state = SEED;
        rst_n_i         <= 1'b0;
        start_i         <= 1'b0;
        op_i            <= OP_ADD;
        count_i         <= '0;
        s_axis_tdata_i  <= '0;
        s_axis_tuser_i  <= BANK_A;
        s_axis_tvalid_i <= 1'b0;
        s_axis_tlast_i  <= 1'b0;
        repeat (3) @(posedge s00_axis_aclk);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge s00_axis_aclk);
        for (int l = 0; l < N_LAYERS; l++) begin
            run_layer(l);
        end
        repeat (4) @(posedge s00_axis_aclk);
        if (layers_seen != N_LAYERS) begin
            $display("checker saw %0d of %0d layers complete", layers_seen, N_LAYERS);
        end
        $display("errors: %0d value, %0d event", value_errs, event_errs);
        if (value_errs == 0 && event_errs == 0 && layers_seen == N_LAYERS) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/npu_pkg.sv
src/sram_if.sv
src/stream_loader.sv
src/sram_banks.sv
src/elementwise_unit.sv
src/layer_controller.sv
src/stream_writer.sv
src/npu_top.sv
testbench/npu_checker.sv
testbench/tb_npu.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    -f filelist.f --top-module tb_npu \
    --Mdir obj_dir -o tb_npu

out=$(./obj_dir/tb_npu)
echo "$out"

if echo "$out" | grep -q "^Done: no errors$"; then
    exit 0
else
    exit 1
fi
